//--- source/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// Bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 32;

	// External pin widths
	localparam int ROM_ADDR_W = 12;
	localparam int DRAM_A_W = 11;
	localparam int DRAM_ROW_W = 7;
	localparam int DRAM_COL_W = 7;

	// Address map, top two bits of the bus address
	localparam logic [1:0] REGION_ROM = 2'd0;
	localparam logic [1:0] REGION_SENSOR = 2'd1;
	localparam logic [1:0] REGION_DRAM = 2'd2;

	// Sensor dumps land in the last DRAM row
	localparam logic [DRAM_ROW_W-1:0] SENSOR_DUMP_ROW = 7'd127;

	// One bus address, read as region/offset or as region/row/column
	typedef union packed {
		struct packed {
			logic [1:0] region;
			logic [ADDR_W-3:0] offset;
		} flat;
		struct packed {
			logic [1:0] region;
			logic [DRAM_ROW_W-1:0] row;
			logic [DRAM_COL_W-1:0] col;
		} dram;
	} bus_addr_u;

endpackage

`default_nettype wire

//--- source/system_bus.sv
`timescale 1ns/100ps
`default_nettype none

module system_bus
	import soc_pkg::*;
(
	input  wire clk,
	input  wire arst_n,
	// Master 0
	input  wire m0_req,
	input  wire m0_we,
	input  wire [ADDR_W-1:0] m0_addr,
	input  wire [DATA_W-1:0] m0_wdata,
	output logic [DATA_W-1:0] m0_rdata,
	output logic m0_done,
	// Master 1
	input  wire m1_req,
	input  wire m1_we,
	input  wire [ADDR_W-1:0] m1_addr,
	input  wire [DATA_W-1:0] m1_wdata,
	output logic [DATA_W-1:0] m1_rdata,
	output logic m1_done,
	// Slave side
	output logic rom_sel,
	output logic dram_sel,
	output logic sensor_sel,
	output logic slv_we,
	output logic [ADDR_W-1:0] slv_addr,
	output logic [DATA_W-1:0] slv_wdata,
	input  wire rom_ack,
	input  wire [DATA_W-1:0] rom_rdata,
	input  wire dram_ack,
	input  wire [DATA_W-1:0] dram_rdata,
	input  wire sensor_ack,
	input  wire [DATA_W-1:0] sensor_rdata
);

	logic busy;
	logic owner;
	logic pick;
	logic bus_ack;
	logic [DATA_W-1:0] bus_rdata;
	bus_addr_u addr_u;

	////////////////////////////////////////////////////////////
	// Round-robin arbiter
	////////////////////////////////////////////////////////////

	// Owner keeps the last served master once the bus goes idle
	assign pick = (m0_req && m1_req) ? !owner : m1_req;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			owner <= 1'b1;
		end else if (!busy) begin
			if (m0_req || m1_req) begin
				busy <= 1'b1;
				owner <= pick;
			end
		end else if (bus_ack) begin
			busy <= 1'b0;
		end
	end

	assign slv_we = owner ? m1_we : m0_we;
	assign slv_addr = owner ? m1_addr : m0_addr;
	assign slv_wdata = owner ? m1_wdata : m0_wdata;
	assign addr_u = slv_addr;

	////////////////////////////////////////////////////////////
	// Region decode and response mux
	////////////////////////////////////////////////////////////

	always_comb begin
		rom_sel = 1'b0;
		dram_sel = 1'b0;
		sensor_sel = 1'b0;
		bus_ack = 1'b0;
		bus_rdata = '0;
		if (busy) begin
			case (addr_u.flat.region)
				REGION_ROM: begin
					rom_sel = 1'b1;
					bus_ack = rom_ack;
					bus_rdata = rom_rdata;
				end
				REGION_SENSOR: begin
					sensor_sel = 1'b1;
					bus_ack = sensor_ack;
					bus_rdata = sensor_rdata;
				end
				REGION_DRAM: begin
					dram_sel = 1'b1;
					bus_ack = dram_ack;
					bus_rdata = dram_rdata;
				end
				// Unmapped, finish at once with zero data
				default: bus_ack = 1'b1;
			endcase
		end
	end

	assign m0_done = bus_ack && !owner;
	assign m1_done = bus_ack && owner;
	assign m0_rdata = bus_rdata;
	assign m1_rdata = bus_rdata;

endmodule

`default_nettype wire

//--- source/rom_port.sv
`timescale 1ns/100ps
`default_nettype none

module rom_port
	import soc_pkg::*;
(
	input  wire clk,
	input  wire arst_n,
	input  wire sel,
	input  wire [ADDR_W-1:0] addr,
	input  wire [DATA_W-1:0] rom_out,
	output logic ack,
	output logic [DATA_W-1:0] rdata,
	output logic rom_read,
	output logic rom_enable,
	output logic [ROM_ADDR_W-1:0] rom_address
);

	logic pending;
	logic start;
	bus_addr_u addr_u;

	assign addr_u = addr;

	// One strobe per select; the ROM has no write path
	assign start = sel && !pending && !ack;
	assign rom_enable = start;
	assign rom_read = start;
	assign rom_address = addr_u.flat.offset[ROM_ADDR_W-1:0];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			ack <= 1'b0;
		end else begin
			pending <= start;
			ack <= pending;
		end
	end

	// ROM word is valid the cycle after the strobe
	always_ff @(posedge clk) begin
		if (pending)
			rdata <= rom_out;
	end

endmodule

`default_nettype wire

//--- source/dram_port.sv
`timescale 1ns/100ps
`default_nettype none

module dram_port
	import soc_pkg::*;
(
	input  wire clk,
	input  wire arst_n,
	input  wire sel,
	input  wire we,
	input  wire [ADDR_W-1:0] addr,
	input  wire [DATA_W-1:0] wdata,
	input  wire [DATA_W-1:0] dram_q,
	input  wire dram_valid,
	output logic ack,
	output logic [DATA_W-1:0] rdata,
	output logic dram_csn,
	output logic [DATA_W/8-1:0] dram_wen,
	output logic dram_rasn,
	output logic dram_casn,
	output logic [DRAM_A_W-1:0] dram_a,
	output logic [DATA_W-1:0] dram_d
);

	localparam logic [2:0] S_IDLE = 3'd0;
	localparam logic [2:0] S_ROW = 3'd1;
	localparam logic [2:0] S_COL = 3'd2;
	localparam logic [2:0] S_WAIT = 3'd3;
	localparam logic [2:0] S_PRE = 3'd4;

	logic [2:0] state;
	bus_addr_u addr_u;

	assign addr_u = addr;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			ack <= 1'b0;
		end else begin
			ack <= 1'b0;
			case (state)
				S_IDLE: if (sel) state <= S_ROW;
				S_ROW: state <= S_COL;
				S_COL: begin
					if (we) begin
						ack <= 1'b1;
						state <= S_PRE;
					end else begin
						state <= S_WAIT;
					end
				end
				// Hold CAS until the part returns data
				S_WAIT: begin
					if (dram_valid) begin
						ack <= 1'b1;
						state <= S_PRE;
					end
				end
				S_PRE: state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_WAIT && dram_valid)
			rdata <= dram_q;
	end

	// Pin drive, chip select spans row through precharge
	assign dram_csn = state == S_IDLE;
	assign dram_rasn = !(state == S_ROW || state == S_COL || state == S_WAIT);
	assign dram_casn = !(state == S_COL || state == S_WAIT);
	assign dram_wen = (state == S_COL && we) ? '0 : '1;
	assign dram_a = (state == S_ROW) ? DRAM_A_W'(addr_u.dram.row) : DRAM_A_W'(addr_u.dram.col);
	assign dram_d = wdata;

endmodule

`default_nettype wire

//--- source/sensor_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module sensor_ctrl
	import soc_pkg::*;
#(
	parameter int SENSOR_DEPTH = 8
) (
	input  wire clk,
	input  wire arst_n,
	input  wire sel,
	input  wire we,
	input  wire [ADDR_W-1:0] addr,
	input  wire sensor_ready,
	input  wire [DATA_W-1:0] sensor_out,
	output logic ack,
	output logic [DATA_W-1:0] rdata,
	output logic sensor_en,
	output logic full
);

	localparam int IDX_W = $clog2(SENSOR_DEPTH);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SENSOR_DEPTH - 1);

	logic [DATA_W-1:0] samples [SENSOR_DEPTH];
	logic [IDX_W-1:0] count;
	logic access;
	bus_addr_u addr_u;

	assign addr_u = addr;
	assign access = sel && !ack;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
			count <= '0;
			full <= 1'b0;
			sensor_en <= 1'b0;
		end else begin
			ack <= access;
			if (access && we) begin
				// Bus write empties the buffer
				count <= '0;
				full <= 1'b0;
				sensor_en <= 1'b1;
			end else if (sensor_en && sensor_ready) begin
				count <= (count == LAST_IDX) ? '0 : count + 1'b1;
				full <= count == LAST_IDX;
				sensor_en <= count != LAST_IDX;
			end else begin
				sensor_en <= !full;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sensor_en && sensor_ready)
			samples[count] <= sensor_out;
		if (access)
			rdata <= samples[addr_u.flat.offset[IDX_W-1:0]];
	end

endmodule

`default_nettype wire

//--- source/sensor_drain.sv
`timescale 1ns/100ps
`default_nettype none

module sensor_drain
	import soc_pkg::*;
#(
	parameter int SENSOR_DEPTH = 8
) (
	input  wire clk,
	input  wire arst_n,
	input  wire full,
	input  wire [DATA_W-1:0] rdata,
	input  wire done,
	output logic req,
	output logic we,
	output logic [ADDR_W-1:0] addr,
	output logic [DATA_W-1:0] wdata
);

	localparam int IDX_W = $clog2(SENSOR_DEPTH);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(SENSOR_DEPTH - 1);

	localparam logic [1:0] S_IDLE = 2'd0;
	localparam logic [1:0] S_READ = 2'd1;
	localparam logic [1:0] S_WRITE = 2'd2;
	localparam logic [1:0] S_CLEAR = 2'd3;

	logic [1:0] state;
	logic [IDX_W-1:0] idx;
	logic [DATA_W-1:0] word;
	bus_addr_u addr_u;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			idx <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					idx <= '0;
					if (full)
						state <= S_READ;
				end
				S_READ: if (done) state <= S_WRITE;
				S_WRITE: begin
					if (done) begin
						idx <= idx + 1'b1;
						state <= (idx == LAST_IDX) ? S_CLEAR : S_READ;
					end
				end
				S_CLEAR: if (done) state <= S_IDLE;
				default: state <= S_IDLE;
			endcase
		end
	end

	// Sample in flight between the buffer and DRAM
	always_ff @(posedge clk) begin
		if (state == S_READ && done)
			word <= rdata;
	end

	always_comb begin
		addr_u = '0;
		if (state == S_WRITE) begin
			addr_u.dram.region = REGION_DRAM;
			addr_u.dram.row = SENSOR_DUMP_ROW;
			addr_u.dram.col[IDX_W-1:0] = idx;
		end else begin
			addr_u.flat.region = REGION_SENSOR;
			if (state == S_READ)
				addr_u.flat.offset[IDX_W-1:0] = idx;
		end
	end

	assign req = state != S_IDLE;
	assign we = state == S_WRITE || state == S_CLEAR;
	assign addr = addr_u;
	assign wdata = word;

endmodule

`default_nettype wire

//--- source/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top
	import soc_pkg::*;
#(
	parameter int SENSOR_DEPTH = 8
) (
	input  wire clk,
	input  wire arst_n,
	// Host
	input  wire host_req,
	input  wire host_we,
	input  wire [ADDR_W-1:0] host_addr,
	input  wire [DATA_W-1:0] host_wdata,
	output logic [DATA_W-1:0] host_rdata,
	output logic host_done,
	// ROM
	input  wire [DATA_W-1:0] rom_out,
	output logic rom_read,
	output logic rom_enable,
	output logic [ROM_ADDR_W-1:0] rom_address,
	// DRAM
	input  wire [DATA_W-1:0] dram_q,
	input  wire dram_valid,
	output logic dram_csn,
	output logic [DATA_W/8-1:0] dram_wen,
	output logic dram_rasn,
	output logic dram_casn,
	output logic [DRAM_A_W-1:0] dram_a,
	output logic [DATA_W-1:0] dram_d,
	// Sensor
	input  wire sensor_ready,
	input  wire [DATA_W-1:0] sensor_out,
	output logic sensor_en
);

	logic drain_req;
	logic drain_we;
	logic [ADDR_W-1:0] drain_addr;
	logic [DATA_W-1:0] drain_wdata;
	logic [DATA_W-1:0] drain_rdata;
	logic drain_done;
	logic rom_sel;
	logic dram_sel;
	logic sensor_sel;
	logic slv_we;
	logic [ADDR_W-1:0] slv_addr;
	logic [DATA_W-1:0] slv_wdata;
	logic rom_ack;
	logic [DATA_W-1:0] rom_rdata;
	logic dram_ack;
	logic [DATA_W-1:0] dram_rdata;
	logic sensor_ack;
	logic [DATA_W-1:0] sensor_rdata;
	logic sensor_full;

	////////////////////////////////////////////////////////////
	// Shared bus, host is master 0 and the drain engine master 1
	////////////////////////////////////////////////////////////
	system_bus bus (
		.clk(clk), .arst_n(arst_n),
		.m0_req(host_req), .m0_we(host_we), .m0_addr(host_addr),
		.m0_wdata(host_wdata), .m0_rdata(host_rdata), .m0_done(host_done),
		.m1_req(drain_req), .m1_we(drain_we), .m1_addr(drain_addr),
		.m1_wdata(drain_wdata), .m1_rdata(drain_rdata), .m1_done(drain_done),
		.rom_sel(rom_sel), .dram_sel(dram_sel), .sensor_sel(sensor_sel),
		.slv_we(slv_we), .slv_addr(slv_addr), .slv_wdata(slv_wdata),
		.rom_ack(rom_ack), .rom_rdata(rom_rdata),
		.dram_ack(dram_ack), .dram_rdata(dram_rdata),
		.sensor_ack(sensor_ack), .sensor_rdata(sensor_rdata)
	);

	////////////////////////////////////////////////////////////
	// Slaves
	////////////////////////////////////////////////////////////
	rom_port rom (
		.clk(clk), .arst_n(arst_n), .sel(rom_sel), .addr(slv_addr),
		.rom_out(rom_out), .ack(rom_ack), .rdata(rom_rdata),
		.rom_read(rom_read), .rom_enable(rom_enable), .rom_address(rom_address)
	);

	dram_port dram (
		.clk(clk), .arst_n(arst_n), .sel(dram_sel), .we(slv_we),
		.addr(slv_addr), .wdata(slv_wdata), .dram_q(dram_q),
		.dram_valid(dram_valid), .ack(dram_ack), .rdata(dram_rdata),
		.dram_csn(dram_csn), .dram_wen(dram_wen), .dram_rasn(dram_rasn),
		.dram_casn(dram_casn), .dram_a(dram_a), .dram_d(dram_d)
	);

	sensor_ctrl #(.SENSOR_DEPTH(SENSOR_DEPTH)) sensor (
		.clk(clk), .arst_n(arst_n), .sel(sensor_sel), .we(slv_we),
		.addr(slv_addr), .sensor_ready(sensor_ready), .sensor_out(sensor_out),
		.ack(sensor_ack), .rdata(sensor_rdata), .sensor_en(sensor_en),
		.full(sensor_full)
	);

	// Empties the sensor buffer into DRAM whenever it fills
	sensor_drain #(.SENSOR_DEPTH(SENSOR_DEPTH)) drain (
		.clk(clk), .arst_n(arst_n), .full(sensor_full),
		.rdata(drain_rdata), .done(drain_done), .req(drain_req),
		.we(drain_we), .addr(drain_addr), .wdata(drain_wdata)
	);

endmodule

`default_nettype wire

//--- tests/soc_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module soc_assertions (
	input wire clk,
	input wire arst_n,
	input wire host_done,
	input wire rom_read,
	input wire rom_enable,
	input wire dram_csn,
	input wire dram_rasn,
	input wire dram_casn,
	input wire [3:0] dram_wen
);

	// CAS only inside a row cycle
	cas_in_ras: assert property (@(posedge clk) disable iff (!arst_n)
		!dram_casn |-> !dram_rasn) else $error("CAS low without RAS");

	rom_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		rom_read |-> rom_enable) else $error("rom_read without rom_enable");

	done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		host_done |=> !host_done) else $error("host_done held two cycles");

	// Deselected part sees no strobes
	csn_quiet: assert property (@(posedge clk) disable iff (!arst_n)
		dram_csn |-> (dram_rasn && dram_casn && &dram_wen))
		else $error("DRAM strobe while deselected");

endmodule

bind soc_top soc_assertions chk (
	.clk(clk), .arst_n(arst_n), .host_done(host_done), .rom_read(rom_read),
	.rom_enable(rom_enable), .dram_csn(dram_csn), .dram_rasn(dram_rasn),
	.dram_casn(dram_casn), .dram_wen(dram_wen)
);

`default_nettype wire

//--- tests/soc_tb.sv
`timescale 1ns/100ps
`default_nettype none

module soc_tb
	import soc_pkg::*;
;

	localparam int DEPTH = 8;

	logic clk = 1'b0;
	logic arst_n;
	logic host_req, host_we, dram_valid, sensor_ready;
	logic [ADDR_W-1:0] host_addr;
	logic [DATA_W-1:0] host_wdata, rom_out, dram_q, sensor_out, host_rdata, dram_d;
	logic host_done, rom_read, rom_enable, dram_csn, dram_rasn, dram_casn, sensor_en;
	logic [ROM_ADDR_W-1:0] rom_address;
	logic [DATA_W/8-1:0] dram_wen;
	logic [DRAM_A_W-1:0] dram_a;

	integer seed = 32'hd48b;
	logic [DATA_W-1:0] dram_mem [logic [13:0]];
	logic [DATA_W-1:0] exp_mem [logic [13:0]];
	logic [13:0] written [$];
	logic [DATA_W-1:0] samples [$];
	logic [DATA_W-1:0] sample;
	logic [DRAM_ROW_W-1:0] open_row;
	logic [ROM_ADDR_W-1:0] last_rom_addr;
	logic rom_fetch;
	logic reading;
	int read_wait, sense_wait;

	soc_top #(.SENSOR_DEPTH(DEPTH)) DUT (.*);

	always #20 clk = !clk;

	task automatic check(string name, logic [31:0] exp, logic [31:0] act);
		if (exp !== act) begin
			$display("ERR %s expected %h actual %h", name, exp, act);
			$display("*** FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	task automatic timed_out(string what);
		$display("Timed out waiting for %s", what);
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	endtask

	function automatic logic [DATA_W-1:0] rom_word(logic [ROM_ADDR_W-1:0] a);
		return DATA_W'(a) * 32'h01010101 + 32'd7;
	endfunction

	function automatic logic [DATA_W-1:0] mem_at(logic [13:0] key);
		return dram_mem.exists(key) ? dram_mem[key] : '0;
	endfunction

	// ROM, DRAM and sensor models all act on the falling edge
	always @(negedge clk) begin
		// ROM word appears the cycle after the strobe
		if (rom_read)
			last_rom_addr <= rom_address;
		rom_fetch <= rom_read;
		if (rom_fetch)
			rom_out <= rom_word(last_rom_addr);
		if (!dram_rasn && dram_casn)
			open_row <= dram_a[DRAM_ROW_W-1:0];
		if (dram_casn) begin
			reading <= 1'b0;
			dram_valid <= 1'b0;
		end else if (dram_wen == '0) begin
			dram_mem[{open_row, dram_a[DRAM_COL_W-1:0]}] = dram_d;
		end else if (!reading) begin
			reading <= 1'b1;
			read_wait = 1 + ($random(seed) & 3);
		end else if (read_wait > 1) begin
			read_wait--;
		end else begin
			dram_valid <= 1'b1;
			dram_q <= mem_at({open_row, dram_a[DRAM_COL_W-1:0]});
		end
		sensor_ready <= 1'b0;
		if (sensor_en) begin
			if (sense_wait > 0) begin
				sense_wait--;
			end else begin
				sample = $random(seed);
				sensor_ready <= 1'b1;
				sensor_out <= sample;
				samples.push_back(sample);
				sense_wait = $random(seed) & 3;
			end
		end
	end

	task automatic access(input logic we, input logic [ADDR_W-1:0] a,
			input logic [DATA_W-1:0] d, output logic [DATA_W-1:0] q);
		int n;
		host_req = 1'b1;
		host_we = we;
		host_addr = a;
		host_wdata = d;
		for (n = 0; n < 300; n++) begin
			@(negedge clk);
			if (host_done)
				break;
		end
		if (n == 300)
			timed_out("host_done");
		q = host_rdata;
		host_req = 1'b0;
	endtask

	task automatic rom_read_check();
		logic [ADDR_W-1:0] a;
		logic [DATA_W-1:0] q;
		a = {REGION_ROM, 14'($random(seed))};
		access(1'b0, a, '0, q);
		check("rom_data", rom_word(a[ROM_ADDR_W-1:0]), q);
		check("rom_address", 32'(a[ROM_ADDR_W-1:0]), 32'(last_rom_addr));
	endtask

	task automatic dram_write();
		logic [13:0] key;
		logic [DATA_W-1:0] d, q;
		key = 14'($random(seed));
		if (key[13:7] == SENSOR_DUMP_ROW)
			key[13] = 1'b0;
		d = $random(seed);
		access(1'b1, {REGION_DRAM, key}, d, q);
		exp_mem[key] = d;
		written.push_back(key);
	endtask

	task automatic dram_read_check();
		logic [13:0] key;
		logic [DATA_W-1:0] q;
		key = written[$unsigned($random(seed)) % written.size()];
		access(1'b0, {REGION_DRAM, key}, '0, q);
		check("dram_read", exp_mem[key], q);
		check("dram_model", exp_mem[key], mem_at(key));
	endtask

	task automatic traffic(int count);
		logic [DATA_W-1:0] q;
		int op;
		repeat (count) begin
			op = $unsigned($random(seed)) % 8;
			if (op < 3)
				rom_read_check();
			else if (op < 5 || written.size() == 0)
				dram_write();
			else if (op < 7)
				dram_read_check();
			else begin
				access(1'b0, {2'd3, 14'($random(seed))}, '0, q);
				check("unmapped", 32'd0, q);
			end
		end
	endtask

	task automatic sensor_en_wait(logic level);
		int n;
		for (n = 0; n < 3000 && sensor_en !== level; n++)
			@(negedge clk);
		if (sensor_en !== level)
			timed_out("sensor_en");
	endtask

	task automatic dump_check();
		int base;
		sensor_en_wait(1'b0);
		check("sample_count", 32'd0, 32'(samples.size() % DEPTH));
		base = samples.size() - DEPTH;
		sensor_en_wait(1'b1);
		for (int i = 0; i < DEPTH; i++)
			check("dump", samples[base+i], mem_at({SENSOR_DUMP_ROW, 7'(i)}));
	endtask

	task automatic idle_outputs(logic en);
		check("host_done", 32'd0, 32'(host_done));
		check("rom_enable", 32'd0, 32'(rom_enable));
		check("rom_read", 32'd0, 32'(rom_read));
		check("dram_csn", 32'd1, 32'(dram_csn));
		check("dram_rasn", 32'd1, 32'(dram_rasn));
		check("dram_casn", 32'd1, 32'(dram_casn));
		check("dram_wen", 32'hf, 32'(dram_wen));
		check("sensor_en", 32'(en), 32'(sensor_en));
	endtask

	initial begin
		arst_n = 1'b0;
		host_req = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		rom_out = '0;
		dram_q = '0;
		dram_valid = 1'b0;
		sensor_ready = 1'b0;
		sensor_out = '0;
		rom_fetch = 1'b0;
		reading = 1'b0;
		sense_wait = 2;
		repeat (8) @(negedge clk);
		idle_outputs(1'b0);
		arst_n = 1'b1;
		@(negedge clk);
		idle_outputs(1'b1);
		traffic(80);
		dump_check();
		traffic(60);
		dump_check();
		traffic(40);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
source/soc_pkg.sv
source/system_bus.sv
source/rom_port.sv
source/dram_port.sv
source/sensor_ctrl.sv
source/sensor_drain.sv
source/soc_top.sv
tests/soc_assertions.sv
tests/soc_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module soc_tb -f verilog.f -o soc_sim \
	&& ./obj_dir/soc_sim \
	|| exit 1
